//--- logic/panel_geom_pkg.sv
// panel geometry for the LED matrix command front end
// default panel size and the fields of a frame memory address
package panel_geom_pkg;

    localparam int DEF_PIXEL_WIDTH = 64;
    localparam int DEF_PIXEL_HEIGHT = 32;
    localparam int DEF_BYTES_PER_PIXEL = 2;
    localparam int DEF_BRIGHTNESS_LEVELS = 6;

    typedef logic [4:0] row_addr_t;
    typedef logic [5:0] col_addr_t;
    typedef logic [0:0] byte_sel_t;

    // byte_sel holds the inverted byte number, so pixel bytes sit
    // little-endian in memory
    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        byte_sel_t byte_sel;
    } frame_addr_t;

endpackage

//--- logic/panel_cmd_pkg.sv
// command encoding for the LED matrix front end
// opcodes, the received byte and the frame memory write
package panel_cmd_pkg;

    typedef enum logic [7:0] {
        OP_RED_ENABLE        = 8'h52,
        OP_RED_DISABLE       = 8'h72,
        OP_GREEN_ENABLE      = 8'h47,
        OP_GREEN_DISABLE     = 8'h67,
        OP_BLUE_ENABLE       = 8'h42,
        OP_BLUE_DISABLE      = 8'h62,
        OP_BRIGHTNESS_ZERO   = 8'h30,
        OP_BRIGHTNESS_ONE    = 8'h31,
        OP_BRIGHTNESS_TWO    = 8'h32,
        OP_BRIGHTNESS_THREE  = 8'h33,
        OP_BRIGHTNESS_FOUR   = 8'h34,
        OP_BRIGHTNESS_FIVE   = 8'h35,
        OP_BRIGHTNESS_SIX    = 8'h36,
        OP_BRIGHTNESS_NINE   = 8'h39,
        OP_READ_BRIGHTNESS   = 8'h54,
        OP_BLANK_PANEL       = 8'h5a,
        OP_READ_PIXEL        = 8'h50
    } cmd_opcode_t;

    // same byte, read as opcode in idle and as argument inside a command
    typedef union packed {
        cmd_opcode_t opcode;
        logic [7:0]  arg;
    } rx_byte_u;

    typedef struct packed {
        panel_geom_pkg::frame_addr_t addr;
        logic [7:0]                  data;
        logic                        we;
    } ram_wr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD_BRIGHTNESS,
        ST_WRITE_PIXEL,
        ST_BLANK
    } cmd_state_t;

endpackage

//--- logic/display_ctrl_regs.sv
// display settings registers
// colour enables and brightness planes, with a pending brightness copy
module display_ctrl_regs
    import panel_geom_pkg::*, panel_cmd_pkg::*;
#(
    parameter int BRIGHTNESS_LEVELS = DEF_BRIGHTNESS_LEVELS
) (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         op_strobe,
    input  cmd_opcode_t                  op_code,
    input  logic                         mask_load,
    input  logic [7:0]                   arg_byte,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable
);
    localparam logic [BRIGHTNESS_LEVELS-1:0] TOP_PLANE = {1'b1, {(BRIGHTNESS_LEVELS-1){1'b0}}};

    logic                         op_valid_q;
    logic                         mask_valid_q;
    cmd_opcode_t                  op_code_q;
    logic [7:0]                   arg_q;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_temp;
    logic [BRIGHTNESS_LEVELS-1:0] plane_mask;
    logic [7:0]                   plane_num;

    // brightness one is the top plane, six the lowest
    always_comb begin
        plane_num = 8'(op_code_q) - 8'(OP_BRIGHTNESS_ONE);
        plane_mask = '0;
        if (op_code_q inside {[OP_BRIGHTNESS_ONE:OP_BRIGHTNESS_SIX]}) begin
            plane_mask = TOP_PLANE >> plane_num;
        end
    end

    always_ff @(posedge clk_in) begin
        if (op_strobe) begin
            op_code_q <= op_code;
        end
        if (mask_load) begin
            arg_q <= arg_byte;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            op_valid_q <= 1'b0;
            mask_valid_q <= 1'b0;
            rgb_enable <= 3'b111;
            brightness_temp <= '1;
            brightness_enable <= '1;
        end else begin
            op_valid_q <= op_strobe;
            mask_valid_q <= mask_load;
            // pending copy goes live one cycle later
            brightness_enable <= brightness_temp;
            if (mask_valid_q) begin
                brightness_temp <= arg_q[BRIGHTNESS_LEVELS-1:0];
            end else if (op_valid_q) begin
                case (op_code_q)
                    OP_RED_ENABLE:      rgb_enable[0] <= 1'b1;
                    OP_RED_DISABLE:     rgb_enable[0] <= 1'b0;
                    OP_GREEN_ENABLE:    rgb_enable[1] <= 1'b1;
                    OP_GREEN_DISABLE:   rgb_enable[1] <= 1'b0;
                    OP_BLUE_ENABLE:     rgb_enable[2] <= 1'b1;
                    OP_BLUE_DISABLE:    rgb_enable[2] <= 1'b0;
                    OP_BRIGHTNESS_ZERO: brightness_temp <= '0;
                    OP_BRIGHTNESS_NINE: brightness_temp <= '1;
                    default:            brightness_temp <= brightness_temp ^ plane_mask;
                endcase
            end
        end
    end

endmodule

//--- logic/cmd_dispatch.sv
// command dispatcher
// latches bytes, runs the command FSM and muxes engine writes to memory
module cmd_dispatch
    import panel_cmd_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  rx_byte_u    data_rx,
    input  logic        data_ready_n,
    output logic        op_strobe,
    output cmd_opcode_t op_code,
    output logic        mask_load,
    output logic [7:0]  arg_byte,
    output logic        pix_start,
    output logic        pix_arg_valid,
    input  ram_wr_t     pix_wr,
    input  logic        pix_done,
    output logic        blank_start,
    input  ram_wr_t     blank_wr,
    input  logic        blank_done,
    output ram_wr_t     ram_wr,
    output logic        busy,
    output logic        ready_for_data
);
    rx_byte_u   rx_latch;
    logic       rx_valid;
    logic       accept;
    logic       cmd_done;
    logic       take_opcode;
    cmd_state_t state;

    assign accept = ~data_ready_n && ready_for_data;

    always_ff @(posedge clk_in) begin
        if (accept) begin
            rx_latch <= data_rx;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= accept;
        end
    end

    // a finishing engine frees the dispatcher for a new opcode in its done cycle
    assign cmd_done = (state == ST_WRITE_PIXEL && pix_done) || (state == ST_BLANK && blank_done);
    assign take_opcode = rx_valid && (state == ST_IDLE || cmd_done);

    assign op_code = rx_latch.opcode;
    assign arg_byte = rx_latch.arg;
    assign op_strobe = take_opcode;
    assign pix_start = take_opcode && rx_latch.opcode == OP_READ_PIXEL;
    assign blank_start = take_opcode && rx_latch.opcode == OP_BLANK_PANEL;
    assign mask_load = rx_valid && state == ST_LOAD_BRIGHTNESS;
    assign pix_arg_valid = rx_valid && state == ST_WRITE_PIXEL && !pix_done;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (take_opcode) begin
            case (rx_latch.opcode)
                OP_READ_BRIGHTNESS: state <= ST_LOAD_BRIGHTNESS;
                OP_READ_PIXEL:      state <= ST_WRITE_PIXEL;
                OP_BLANK_PANEL:     state <= ST_BLANK;
                default:            state <= ST_IDLE;
            endcase
        end else if (cmd_done || mask_load) begin
            state <= ST_IDLE;
        end
    end

    always_comb begin
        case (state)
            ST_WRITE_PIXEL: ram_wr = pix_wr;
            ST_BLANK:       ram_wr = blank_wr;
            default:        ram_wr = '0;
        endcase
    end

    assign busy = state != ST_IDLE;
    // blanking takes no arguments, so hold the sender off until it ends
    assign ready_for_data = ~((state == ST_BLANK && !blank_done) || blank_start);

    a_no_write_in_idle: assert property (@(posedge clk_in) disable iff (reset)
        state == ST_IDLE |-> !(pix_wr.we || blank_wr.we));

    // engine done only while its own command is running
    a_done_in_own_state: assert property (@(posedge clk_in) disable iff (reset)
        (!pix_done || state == ST_WRITE_PIXEL) && (!blank_done || state == ST_BLANK));

endmodule

//--- logic/pixel_write_cmd.sv
// write-one-pixel engine
// takes row, column and pixel bytes, one memory write per pixel byte
module pixel_write_cmd
    import panel_geom_pkg::*, panel_cmd_pkg::*;
#(
    parameter int BYTES_PER_PIXEL = DEF_BYTES_PER_PIXEL
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       start,
    input  logic       arg_valid,
    input  logic [7:0] arg_byte,
    output ram_wr_t    wr,
    output logic       done
);
    // row and column come before the pixel bytes
    localparam int ARG_COUNT = BYTES_PER_PIXEL + 2;
    localparam int CNT_W = $clog2(ARG_COUNT);

    logic [CNT_W-1:0] arg_cnt;
    logic [CNT_W-1:0] byte_num;
    logic             last_byte;
    logic             is_data;
    row_addr_t        row_q;
    col_addr_t        col_q;
    frame_addr_t      wr_addr;
    logic [7:0]       wr_data;
    logic             wr_we;

    assign byte_num = arg_cnt - CNT_W'(2);
    assign last_byte = arg_cnt == CNT_W'(ARG_COUNT - 1);
    assign is_data = arg_cnt >= CNT_W'(2);

    always_ff @(posedge clk_in) begin
        if (arg_valid && arg_cnt == '0) begin
            row_q <= row_addr_t'(arg_byte);
        end
        if (arg_valid && arg_cnt == CNT_W'(1)) begin
            col_q <= col_addr_t'(arg_byte);
        end
        if (arg_valid && is_data) begin
            wr_addr.row <= row_q;
            wr_addr.col <= col_q;
            wr_addr.byte_sel <= ~byte_sel_t'(byte_num);
            wr_data <= arg_byte;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_cnt <= '0;
            wr_we <= 1'b0;
            done <= 1'b0;
        end else begin
            wr_we <= 1'b0;
            done <= 1'b0;
            if (start) begin
                arg_cnt <= '0;
            end else if (arg_valid) begin
                arg_cnt <= last_byte ? '0 : arg_cnt + CNT_W'(1);
                wr_we <= is_data;
                done <= last_byte;
            end
        end
    end

    assign wr = '{addr: wr_addr, data: wr_data, we: wr_we};

    // a new command never cuts into an unfinished one
    a_start_between_commands: assert property (@(posedge clk_in) disable iff (reset)
        start |-> arg_cnt == '0);

endmodule

//--- logic/blank_panel_cmd.sv
// blank-panel engine
// writes zero to every frame byte, one address per clock
module blank_panel_cmd
    import panel_geom_pkg::*, panel_cmd_pkg::*;
#(
    parameter int PIXEL_WIDTH = DEF_PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = DEF_PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = DEF_BYTES_PER_PIXEL
) (
    input  logic    clk_in,
    input  logic    reset,
    input  logic    start,
    output ram_wr_t wr,
    output logic    done
);
    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int CNT_W = $bits(frame_addr_t);

    logic [CNT_W-1:0] cnt;
    logic             active;
    logic             last_addr;
    frame_addr_t      wr_addr;
    logic             wr_we;

    assign last_addr = cnt == CNT_W'(FRAME_BYTES - 1);

    always_ff @(posedge clk_in) begin
        wr_addr <= frame_addr_t'(cnt);
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            cnt <= '0;
            active <= 1'b0;
            wr_we <= 1'b0;
            done <= 1'b0;
        end else begin
            wr_we <= active;
            done <= active && last_addr;
            if (start) begin
                cnt <= '0;
                active <= 1'b1;
            end else if (active) begin
                cnt <= cnt + CNT_W'(1);
                // stop after the final address has gone out
                if (last_addr) begin
                    active <= 1'b0;
                end
            end
        end
    end

    assign wr = '{addr: wr_addr, data: 8'h00, we: wr_we};

endmodule

//--- logic/panel_cmd_top.sv
// LED matrix command front end top level
// connects the dispatcher, settings registers and memory engines
module panel_cmd_top
    import panel_geom_pkg::*, panel_cmd_pkg::*;
#(
    parameter int PIXEL_WIDTH = DEF_PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = DEF_PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = DEF_BYTES_PER_PIXEL,
    parameter int BRIGHTNESS_LEVELS = DEF_BRIGHTNESS_LEVELS
) (
    input  logic                         clk_in,
    input  logic                         reset,
    input  rx_byte_u                     data_rx,
    input  logic                         data_ready_n,
    output logic [2:0]                   rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output ram_wr_t                      ram_wr,
    output logic                         busy,
    output logic                         ready_for_data
);
    logic        op_strobe;
    cmd_opcode_t op_code;
    logic        mask_load;
    logic [7:0]  arg_byte;
    logic        pix_start;
    logic        pix_arg_valid;
    ram_wr_t     pix_wr;
    logic        pix_done;
    logic        blank_start;
    ram_wr_t     blank_wr;
    logic        blank_done;

    cmd_dispatch dispatch (
        .clk_in(clk_in), .reset(reset), .data_rx(data_rx), .data_ready_n(data_ready_n),
        .op_strobe(op_strobe), .op_code(op_code), .mask_load(mask_load), .arg_byte(arg_byte),
        .pix_start(pix_start), .pix_arg_valid(pix_arg_valid), .pix_wr(pix_wr),
        .pix_done(pix_done), .blank_start(blank_start), .blank_wr(blank_wr),
        .blank_done(blank_done), .ram_wr(ram_wr), .busy(busy), .ready_for_data(ready_for_data)
    );

    display_ctrl_regs #(.BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)) ctrl_regs (
        .clk_in(clk_in), .reset(reset), .op_strobe(op_strobe), .op_code(op_code),
        .mask_load(mask_load), .arg_byte(arg_byte), .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable)
    );

    pixel_write_cmd #(.BYTES_PER_PIXEL(BYTES_PER_PIXEL)) pixel_write (
        .clk_in(clk_in), .reset(reset), .start(pix_start), .arg_valid(pix_arg_valid),
        .arg_byte(arg_byte), .wr(pix_wr), .done(pix_done)
    );

    blank_panel_cmd #(
        .PIXEL_WIDTH(PIXEL_WIDTH), .PIXEL_HEIGHT(PIXEL_HEIGHT), .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) blank_panel (
        .clk_in(clk_in), .reset(reset), .start(blank_start), .wr(blank_wr), .done(blank_done)
    );

endmodule

//--- verif/panel_cmd_tb.sv
// testbench for the LED matrix command front end
// random commands checked against a model of settings and frame memory
module panel_cmd_tb
    import panel_geom_pkg::*, panel_cmd_pkg::*;
();
    localparam int N_OTHER = 180;
    localparam int N_BLANK = 2;
    localparam int CYCLE_LIMIT = N_BLANK * 4200 + N_OTHER * 40 + 1000;
    localparam int FRAME_BYTES = 4096;
    localparam int LEVELS = DEF_BRIGHTNESS_LEVELS;

    logic              clk_in;
    logic              reset;
    rx_byte_u          data_rx;
    logic              data_ready_n;
    logic [2:0]        rgb_enable;
    logic [LEVELS-1:0] brightness_enable;
    ram_wr_t           ram_wr;
    logic              busy;
    logic              ready_for_data;

    logic [31:0]       rng = 32'hb3fd;
    int                errors = 0;
    int                writes = 0;
    int                cycles = 0;
    logic [2:0]        rgb_model;
    logic [LEVELS-1:0] bright_model;
    logic [7:0]        model_mem [FRAME_BYTES];
    logic [7:0]        dut_mem [FRAME_BYTES];
    ram_wr_t           exp_q [$];

    panel_cmd_top uut (
        .clk_in(clk_in), .reset(reset), .data_rx(data_rx), .data_ready_n(data_ready_n),
        .rgb_enable(rgb_enable), .brightness_enable(brightness_enable), .ram_wr(ram_wr),
        .busy(busy), .ready_for_data(ready_for_data)
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // sender holds off while ready_for_data is low
    task automatic send_byte(input logic [7:0] b);
        while (!ready_for_data) begin
            @(posedge clk_in);
            #5;
        end
        data_rx.arg = b;
        data_ready_n = 1'b0;
        @(posedge clk_in);
        #5;
        data_ready_n = 1'b1;
    endtask

    task automatic drain_writes(input bit blanking);
        while (exp_q.size() != 0) begin
            // only the last blank write may see ready high
            if (blanking && exp_q.size() > 1) begin
                compare_value("ready_for_data", 0, ready_for_data);
            end
            @(posedge clk_in);
            #5;
        end
        compare_value("busy", 0, busy);
    endtask

    task automatic settle_and_check();
        repeat (8) begin
            @(posedge clk_in);
            #5;
        end
        compare_value("busy", 0, busy);
        compare_value("rgb_enable", rgb_model, rgb_enable);
        compare_value("brightness_enable", bright_model, brightness_enable);
    endtask

    task automatic pixel_write();
        logic [7:0] row;
        logic [7:0] col;
        ram_wr_t    w;
        rng = xorshift(rng);
        row = rng[7:0];
        col = rng[15:8];
        send_byte(OP_READ_PIXEL);
        send_byte(row);
        send_byte(col);
        for (int i = 0; i < DEF_BYTES_PER_PIXEL; i++) begin
            rng = xorshift(rng);
            w.addr.row = row[4:0];
            w.addr.col = col[5:0];
            // inverted byte number, little-endian pixel
            w.addr.byte_sel = ~1'(i);
            w.data = rng[7:0];
            w.we = 1'b1;
            exp_q.push_back(w);
            model_mem[w.addr] = w.data;
            send_byte(w.data);
        end
        drain_writes(1'b0);
    endtask

    task automatic blank_panel();
        ram_wr_t w;
        for (int a = 0; a < FRAME_BYTES; a++) begin
            w.addr = 12'(a);
            w.data = 8'h00;
            w.we = 1'b1;
            exp_q.push_back(w);
            model_mem[a] = 8'h00;
        end
        send_byte(OP_BLANK_PANEL);
        drain_writes(1'b1);
    endtask

    task automatic random_command();
        int          sel;
        int          plane;
        cmd_opcode_t op;
        rng = xorshift(rng);
        sel = int'(rng % 13);
        plane = int'(rng[10:8]) % LEVELS;
        case (sel)
            0: op = OP_RED_ENABLE;
            1: op = OP_RED_DISABLE;
            2: op = OP_GREEN_ENABLE;
            3: op = OP_GREEN_DISABLE;
            4: op = OP_BLUE_ENABLE;
            5: op = OP_BLUE_DISABLE;
            6: op = OP_BRIGHTNESS_ZERO;
            7: op = OP_BRIGHTNESS_NINE;
            8: op = OP_READ_BRIGHTNESS;
            9: op = OP_READ_PIXEL;
            default: op = cmd_opcode_t'(8'(OP_BRIGHTNESS_ONE) + 8'(plane));
        endcase
        if (op == OP_READ_PIXEL) begin
            pixel_write();
        end else begin
            send_byte(op);
            if (op == OP_READ_BRIGHTNESS) begin
                send_byte(rng[23:16]);
            end
        end
        // red is bit 0, blue bit 2; even selections enable
        if (sel < 6) begin
            rgb_model[sel / 2] = ~sel[0];
        end else if (sel == 6) begin
            bright_model = '0;
        end else if (sel == 7) begin
            bright_model = '1;
        end else if (sel == 8) begin
            bright_model = rng[16 +: LEVELS];
        end else if (sel > 9) begin
            bright_model[LEVELS - 1 - plane] = ~bright_model[LEVELS - 1 - plane];
        end
        settle_and_check();
    endtask

    // every write strobe is matched against the next expected write
    always @(negedge clk_in) begin
        if (!reset && ram_wr.we) begin
            writes++;
            dut_mem[ram_wr.addr] = ram_wr.data;
            if (exp_q.size() == 0) begin
                errors++;
                $display("memory write at %0t to address %03h outside any command",
                         $time, ram_wr.addr);
            end else begin
                compare_value("ram_wr.addr", exp_q[0].addr, ram_wr.addr);
                compare_value("ram_wr.data", exp_q[0].data, ram_wr.data);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d errors", cycles, errors);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        clk_in = 1'b0;
        reset = 1'b1;
        data_rx = '0;
        data_ready_n = 1'b1;
        rgb_model = '1;
        bright_model = '1;
        for (int a = 0; a < FRAME_BYTES; a++) begin
            model_mem[a] = 8'(a ^ (a >> 8) ^ 8'h5a);
            dut_mem[a] = model_mem[a];
        end
        repeat (16) @(posedge clk_in);
        #5;
        reset = 1'b0;
        compare_value("rgb_enable", 3'b111, rgb_enable);
        compare_value("brightness_enable", {LEVELS{1'b1}}, brightness_enable);
        compare_value("busy", 0, busy);
        compare_value("ready_for_data", 1, ready_for_data);

        repeat (120) random_command();
        blank_panel();
        settle_and_check();
        repeat (30) random_command();
        blank_panel();
        settle_and_check();
        repeat (30) begin
            pixel_write();
            settle_and_check();
        end

        for (int a = 0; a < FRAME_BYTES; a++) begin
            compare_value($sformatf("frame_mem[%03h]", a), model_mem[a], dut_mem[a]);
        end
        $display("run finished with %0d errors over %0d memory writes", errors, writes);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
logic/panel_geom_pkg.sv
logic/panel_cmd_pkg.sv
logic/display_ctrl_regs.sv
logic/cmd_dispatch.sv
logic/pixel_write_cmd.sv
logic/blank_panel_cmd.sv
logic/panel_cmd_top.sv
verif/panel_cmd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the LED matrix command front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module panel_cmd_tb \
    --Mdir obj_dir -o panel_cmd_sim

./obj_dir/panel_cmd_sim > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
